// File: logic/alu_config.svh
`ifndef ALU_CONFIG_SVH
`define ALU_CONFIG_SVH

// operand width with hi/lo twice as wide
`define ALU_DATA_W 32

// shift amount field
`define ALU_SHAMT_W 5

// multiplier bits retired per cycle (1, 2, 4 or 8)
`define MUL_BITS_PER_STEP 2

`endif

// File: logic/alu_pkg.sv
package alu_pkg;

    // execute-stage operation codes
    typedef enum logic [7:0] {
        op_pass  = 8'h00,
        op_and   = 8'h01,
        op_or    = 8'h02,
        op_nor   = 8'h03,
        op_xor   = 8'h04,
        op_add   = 8'h05,
        op_addu  = 8'h06,
        op_sub   = 8'h07,
        op_subu  = 8'h08,
        op_slt   = 8'h09,
        op_sltu  = 8'h0a,
        op_sllv  = 8'h0b,
        op_srlv  = 8'h0c,
        op_srav  = 8'h0d,
        op_sll   = 8'h0e,
        op_srl   = 8'h0f,
        op_sra   = 8'h10,
        op_lui   = 8'h11,
        op_seb   = 8'h12,
        op_seh   = 8'h13,
        op_wsbh  = 8'h14,
        // multi-cycle group
        op_mult  = 8'h15,
        op_multu = 8'h16,
        op_div   = 8'h17,
        op_divu  = 8'h18,
        op_mul   = 8'h19,
        op_madd  = 8'h1a,
        op_maddu = 8'h1b,
        op_msub  = 8'h1c,
        op_msubu = 8'h1d,
        // hi/lo moves
        op_mthi  = 8'h1e,
        op_mtlo  = 8'h1f,
        op_mfhi  = 8'h20,
        op_mflo  = 8'h21
    } alu_op_e;

    // per-unit request sequencer in the alu
    typedef enum logic [1:0] {st_idle, st_busy, st_release} unit_state_e;

    // hi/lo write select
    typedef enum logic [1:0] {sel_both, sel_hi, sel_lo} hilo_sel_e;

    // iterative unit states where mul never enters cs_fix
    typedef enum logic [1:0] {cs_idle, cs_run, cs_fix, cs_done} core_state_e;

endpackage

// File: logic/muldiv_if.sv
`include "alu_config.svh"

interface muldiv_if;

    logic [`ALU_DATA_W-1:0]   op_a;
    logic [`ALU_DATA_W-1:0]   op_b;
    logic                     is_signed;
    logic                     start;
    logic                     ready;
    // {hi, lo} of the unit's answer
    logic [2*`ALU_DATA_W-1:0] result;

    modport requester (
        output op_a, op_b, is_signed, start,
        input  ready, result
    );

    modport unit (
        input  op_a, op_b, is_signed, start,
        output ready, result
    );

endinterface

// File: logic/mul_unit.sv
`include "alu_config.svh"

module mul_unit (
    input  logic   clk,
    input  logic   reset_i,
    input  logic   flush_i,
    muldiv_if.unit bus
);
    import alu_pkg::*;

    localparam int W       = `ALU_DATA_W;
    localparam int STEP    = `MUL_BITS_PER_STEP;
    localparam int N_STEPS = W / STEP;
    localparam int CNT_W   = $clog2(N_STEPS);

    core_state_e      state_q;
    logic [CNT_W-1:0] count_q;
    logic [2*W-1:0]   mcand_q;
    logic [W-1:0]     mplier_q;
    logic [2*W-1:0]   acc_q;
    logic [2*W-1:0]   acc_next;
    logic [2*W-1:0]   result_q;
    logic             neg_q;
    logic [W-1:0]     mag_a;
    logic [W-1:0]     mag_b;
    logic             last_step;

    assign mag_a     = (bus.is_signed && bus.op_a[W-1]) ? -bus.op_a : bus.op_a;
    assign mag_b     = (bus.is_signed && bus.op_b[W-1]) ? -bus.op_b : bus.op_b;
    assign last_step = (count_q == CNT_W'(N_STEPS - 1));

    // add in the partial products for this step's multiplier bits
    always_comb begin
        acc_next = acc_q;
        for (int i = 0; i < STEP; i++) begin
            if (mplier_q[i]) acc_next = acc_next + (mcand_q << i);
        end
    end

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            state_q <= cs_idle;
        end else begin
            case (state_q)
                cs_idle: if (bus.start) state_q <= cs_run;
                cs_run:  if (last_step) state_q <= cs_done;
                cs_done: if (!bus.start) state_q <= cs_idle;
                default: state_q <= cs_idle;
            endcase
        end
    end

    // operands keep loading while idle so the start cycle captures them
    always_ff @(posedge clk) begin
        case (state_q)
            cs_idle: begin
                mcand_q  <= {{W{1'b0}}, mag_a};
                mplier_q <= mag_b;
                acc_q    <= '0;
                count_q  <= '0;
                neg_q    <= bus.is_signed & (bus.op_a[W-1] ^ bus.op_b[W-1]);
            end
            cs_run: begin
                mcand_q  <= mcand_q << STEP;
                mplier_q <= mplier_q >> STEP;
                acc_q    <= acc_next;
                count_q  <= count_q + 1'b1;
                if (last_step) result_q <= neg_q ? -acc_next : acc_next;
            end
            default: ;
        endcase
    end

    assign bus.ready  = (state_q == cs_done);
    assign bus.result = result_q;

    ready_held_a: assert property (@(posedge clk) disable iff (reset_i)
        $fell(bus.ready) |-> ($past(!bus.start) || $past(flush_i) || $past(reset_i)));

endmodule

// File: logic/div_unit.sv
`include "alu_config.svh"

module div_unit (
    input  logic   clk,
    input  logic   reset_i,
    input  logic   flush_i,
    muldiv_if.unit bus
);
    import alu_pkg::*;

    localparam int W     = `ALU_DATA_W;
    localparam int CNT_W = $clog2(W);

    core_state_e      state_q;
    logic [CNT_W-1:0] count_q;
    logic [W-1:0]     divisor_q;
    // dividend bits shift out the top while quotient bits shift in
    logic [W-1:0]     quo_q;
    logic [W-1:0]     rem_q;
    logic             quo_neg_q;
    logic             rem_neg_q;
    logic [W:0]       partial;
    logic [W:0]       diff;
    logic [2*W-1:0]   result_q;
    logic [W-1:0]     mag_a;
    logic [W-1:0]     mag_b;
    logic             last_step;

    assign mag_a     = (bus.is_signed && bus.op_a[W-1]) ? -bus.op_a : bus.op_a;
    assign mag_b     = (bus.is_signed && bus.op_b[W-1]) ? -bus.op_b : bus.op_b;
    assign last_step = (count_q == CNT_W'(W - 1));

    // trial subtract of one restoring step
    assign partial = {rem_q, quo_q[W-1]};
    assign diff    = partial - {1'b0, divisor_q};

    always_ff @(posedge clk) begin
        if (reset_i || flush_i) begin
            state_q <= cs_idle;
        end else begin
            case (state_q)
                cs_idle: if (bus.start) state_q <= cs_run;
                cs_run:  if (last_step) state_q <= cs_fix;
                cs_fix:  state_q <= cs_done;
                cs_done: if (!bus.start) state_q <= cs_idle;
                default: state_q <= cs_idle;
            endcase
        end
    end

    // a zero divisor never fails the trial subtract, so the quotient
    // comes out all ones and the remainder is the dividend magnitude
    always_ff @(posedge clk) begin
        case (state_q)
            cs_idle: begin
                divisor_q <= mag_b;
                quo_q     <= mag_a;
                rem_q     <= '0;
                count_q   <= '0;
                quo_neg_q <= bus.is_signed & (bus.op_a[W-1] ^ bus.op_b[W-1]);
                rem_neg_q <= bus.is_signed & bus.op_a[W-1];
            end
            cs_run: begin
                count_q <= count_q + 1'b1;
                if (!diff[W]) begin
                    rem_q <= diff[W-1:0];
                    quo_q <= {quo_q[W-2:0], 1'b1};
                end else begin
                    rem_q <= partial[W-1:0];
                    quo_q <= {quo_q[W-2:0], 1'b0};
                end
            end
            cs_fix: begin
                // remainder follows the dividend sign
                result_q[2*W-1:W] <= rem_neg_q ? -rem_q : rem_q;
                result_q[W-1:0]   <= quo_neg_q ? -quo_q : quo_q;
            end
            default: ;
        endcase
    end

    assign bus.ready  = (state_q == cs_done);
    assign bus.result = result_q;

endmodule

// File: logic/hilo_reg.sv
`include "alu_config.svh"

module hilo_reg (
    input  logic                       clk,
    input  logic                       reset_i,
    input  logic                       we_i,
    input  alu_pkg::hilo_sel_e         sel_i,
    input  logic [2*`ALU_DATA_W-1:0]   data_i,
    output logic [2*`ALU_DATA_W-1:0]   hilo_o
);
    import alu_pkg::*;

    localparam int W = `ALU_DATA_W;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            hilo_o <= '0;
        end else if (we_i) begin
            case (sel_i)
                sel_both: hilo_o <= data_i;
                // single-half moves leave the other half alone
                sel_hi:   hilo_o[2*W-1:W] <= data_i[2*W-1:W];
                sel_lo:   hilo_o[W-1:0] <= data_i[W-1:0];
                default:  ;
            endcase
        end
    end

endmodule

// File: logic/alu.sv
`include "alu_config.svh"

module alu (
    input  logic                     clk,
    input  logic                     reset_i,
    input  logic                     flush_i,
    input  logic                     flush_exception_i,
    input  alu_pkg::alu_op_e         op_i,
    input  logic [`ALU_DATA_W-1:0]   src_a_i,
    input  logic [`ALU_DATA_W-1:0]   src_b_i,
    input  logic [`ALU_SHAMT_W-1:0]  sa_i,
    output logic                     stall_o,
    output logic [`ALU_DATA_W-1:0]   result_o,
    output logic                     overflow_o
);
    import alu_pkg::*;

    localparam int W = `ALU_DATA_W;

    muldiv_if mul_bus ();
    muldiv_if div_bus ();

    unit_state_e    mul_st_q;
    unit_state_e    div_st_q;
    logic           is_mul_op;
    logic           is_div_op;
    logic           mul_signed;
    logic           div_signed;
    logic           mul_done;
    logic           div_done;
    logic [W-1:0]   add_res;
    logic [W-1:0]   sub_res;
    logic           hilo_we_raw;
    logic           hilo_we;
    hilo_sel_e      hilo_sel;
    logic [2*W-1:0] hilo_d;
    logic [2*W-1:0] hilo_q;

    // request sequencer shared by both units
    function automatic unit_state_e seq_next(unit_state_e st, logic want, logic rdy);
        unit_state_e nxt;
        nxt = st;
        case (st)
            st_idle:    if (want) nxt = st_busy;
            st_busy:    if (rdy) nxt = st_release;
            // wait for the unit to drop ready before a new request
            st_release: if (!rdy) nxt = st_idle;
            default:    nxt = st_idle;
        endcase
        return nxt;
    endfunction

    always_comb begin
        is_mul_op  = 1'b0;
        mul_signed = 1'b0;
        is_div_op  = 1'b0;
        div_signed = 1'b0;
        case (op_i)
            op_mult, op_mul, op_madd, op_msub: begin
                is_mul_op  = 1'b1;
                mul_signed = 1'b1;
            end
            op_multu, op_maddu, op_msubu: is_mul_op = 1'b1;
            op_div: begin
                is_div_op  = 1'b1;
                div_signed = 1'b1;
            end
            op_divu: is_div_op = 1'b1;
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            mul_st_q <= st_idle;
            div_st_q <= st_idle;
        end else if (flush_i) begin
            mul_st_q <= st_idle;
            div_st_q <= st_idle;
        end else begin
            mul_st_q <= seq_next(mul_st_q, is_mul_op, mul_bus.ready);
            div_st_q <= seq_next(div_st_q, is_div_op, div_bus.ready);
        end
    end

    assign mul_done = (mul_st_q == st_busy) & mul_bus.ready;
    assign div_done = (div_st_q == st_busy) & div_bus.ready;

    // start drops in the cycle ready is seen
    assign mul_bus.op_a      = src_a_i;
    assign mul_bus.op_b      = src_b_i;
    assign mul_bus.is_signed = mul_signed;
    assign mul_bus.start     = ((mul_st_q == st_idle) & is_mul_op) |
                               ((mul_st_q == st_busy) & ~mul_bus.ready);
    assign div_bus.op_a      = src_a_i;
    assign div_bus.op_b      = src_b_i;
    assign div_bus.is_signed = div_signed;
    assign div_bus.start     = ((div_st_q == st_idle) & is_div_op) |
                               ((div_st_q == st_busy) & ~div_bus.ready);

    assign stall_o = ((is_mul_op & ~mul_done) | (is_div_op & ~div_done)) & ~flush_i;

    mul_unit u_mul (.clk(clk), .reset_i(reset_i), .flush_i(flush_i), .bus(mul_bus));
    div_unit u_div (.clk(clk), .reset_i(reset_i), .flush_i(flush_i), .bus(div_bus));

    assign add_res = src_a_i + src_b_i;
    assign sub_res = src_a_i - src_b_i;

    always_comb begin
        result_o   = '0;
        overflow_o = 1'b0;
        case (op_i)
            op_pass: result_o = src_a_i;
            op_and:  result_o = src_a_i & src_b_i;
            op_or:   result_o = src_a_i | src_b_i;
            op_nor:  result_o = ~(src_a_i | src_b_i);
            op_xor:  result_o = src_a_i ^ src_b_i;
            op_add: begin
                result_o   = add_res;
                overflow_o = (src_a_i[W-1] == src_b_i[W-1]) & (add_res[W-1] != src_a_i[W-1]);
            end
            op_addu: result_o = add_res;
            op_sub: begin
                result_o   = sub_res;
                overflow_o = (src_a_i[W-1] != src_b_i[W-1]) & (sub_res[W-1] != src_a_i[W-1]);
            end
            op_subu: result_o = sub_res;
            op_slt:  result_o = {{(W-1){1'b0}}, $signed(src_a_i) < $signed(src_b_i)};
            op_sltu: result_o = {{(W-1){1'b0}}, src_a_i < src_b_i};
            op_sllv: result_o = src_b_i << src_a_i[`ALU_SHAMT_W-1:0];
            op_srlv: result_o = src_b_i >> src_a_i[`ALU_SHAMT_W-1:0];
            op_srav: result_o = $signed(src_b_i) >>> src_a_i[`ALU_SHAMT_W-1:0];
            op_sll:  result_o = src_b_i << sa_i;
            op_srl:  result_o = src_b_i >> sa_i;
            op_sra:  result_o = $signed(src_b_i) >>> sa_i;
            op_lui:  result_o = {src_b_i[W/2-1:0], {(W/2){1'b0}}};
            op_seb:  result_o = {{(W-8){src_b_i[7]}}, src_b_i[7:0]};
            op_seh:  result_o = {{(W-16){src_b_i[15]}}, src_b_i[15:0]};
            // swap bytes within each halfword
            op_wsbh: result_o = {src_b_i[23:16], src_b_i[31:24], src_b_i[7:0], src_b_i[15:8]};
            op_mul:  result_o = mul_done ? mul_bus.result[W-1:0] : '0;
            op_mfhi: result_o = hilo_q[2*W-1:W];
            op_mflo: result_o = hilo_q[W-1:0];
            default: result_o = '0;
        endcase
    end

    // hi/lo update where op_mul writes nothing
    always_comb begin
        hilo_we_raw = 1'b0;
        hilo_sel    = sel_both;
        hilo_d      = mul_bus.result;
        case (op_i)
            op_mult, op_multu: hilo_we_raw = mul_done;
            op_madd, op_maddu: begin
                hilo_we_raw = mul_done;
                hilo_d      = hilo_q + mul_bus.result;
            end
            op_msub, op_msubu: begin
                hilo_we_raw = mul_done;
                hilo_d      = hilo_q - mul_bus.result;
            end
            op_div, op_divu: begin
                hilo_we_raw = div_done;
                hilo_d      = div_bus.result;
            end
            op_mthi: begin
                hilo_we_raw = 1'b1;
                hilo_sel    = sel_hi;
                hilo_d      = {src_a_i, {W{1'b0}}};
            end
            op_mtlo: begin
                hilo_we_raw = 1'b1;
                hilo_sel    = sel_lo;
                hilo_d      = {{W{1'b0}}, src_a_i};
            end
            default: ;
        endcase
    end

    // exception in the next stage or a flush kills the write
    assign hilo_we = hilo_we_raw & ~flush_exception_i & ~flush_i;

    hilo_reg u_hilo (
        .clk    (clk),
        .reset_i(reset_i),
        .we_i   (hilo_we),
        .sel_i  (hilo_sel),
        .data_i (hilo_d),
        .hilo_o (hilo_q)
    );

    mul_start_a: assert property (@(posedge clk) disable iff (reset_i)
        $rose(mul_bus.start) |-> !mul_bus.ready);
    div_start_a: assert property (@(posedge clk) disable iff (reset_i)
        $rose(div_bus.start) |-> !div_bus.ready);
    stall_op_a: assert property (@(posedge clk) disable iff (reset_i)
        stall_o |-> op_i inside {op_mult, op_multu, op_div, op_divu, op_mul,
                                 op_madd, op_maddu, op_msub, op_msubu});

endmodule

// File: verif/tb_alu.sv
`include "alu_config.svh"

module tb_alu;
    timeunit 1ns;
    timeprecision 100ps;
    import alu_pkg::*;

    localparam int W        = `ALU_DATA_W;
    localparam int REC_W    = 136;
    localparam int MAX_RECS = 128;
    localparam int TIMEOUT  = 100;

    logic                    clk;
    logic                    reset_i;
    logic                    flush_i;
    logic                    flush_exception_i;
    alu_op_e                 op_i;
    logic [W-1:0]            src_a_i;
    logic [W-1:0]            src_b_i;
    logic [`ALU_SHAMT_W-1:0] sa_i;
    logic                    stall_o;
    logic [W-1:0]            result_o;
    logic                    overflow_o;

    // id, op, src_a, src_b, sa, flags, expected result, expected overflow
    logic [REC_W-1:0] patterns [MAX_RECS];
    integer           seed;
    int               errors;
    int               tests;
    logic             aborted;

    alu dut (
        .clk              (clk),
        .reset_i          (reset_i),
        .flush_i          (flush_i),
        .flush_exception_i(flush_exception_i),
        .op_i             (op_i),
        .src_a_i          (src_a_i),
        .src_b_i          (src_b_i),
        .sa_i             (sa_i),
        .stall_o          (stall_o),
        .result_o         (result_o),
        .overflow_o       (overflow_o)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic drive_idle();
        op_i              = op_pass;
        src_a_i           = '0;
        src_b_i           = '0;
        sa_i              = '0;
        flush_i           = 1'b0;
        flush_exception_i = 1'b0;
    endtask

    // one sample per cycle shortly after the falling edge
    task automatic wait_stall_low(output logic timed_out);
        int cycles;
        cycles = 0;
        while (stall_o && cycles < TIMEOUT) begin
            @(negedge clk);
            #2;
            cycles++;
        end
        timed_out = stall_o;
    endtask

    task automatic check_stall(input logic [7:0] id, input logic expected);
        assert (stall_o === expected) else begin
            $display("[FAIL] test %02h stall_o got %h expected %h", id, stall_o, expected);
            errors++;
        end
    endtask

    // flags hold [7] flush_exception, [6] multi-cycle, [5] no gap, [3:0] flush after n cycles
    task automatic run_record(input logic [REC_W-1:0] rec, output logic timed_out);
        logic [7:0]   id;
        logic [7:0]   flags;
        logic [W-1:0] exp_res;
        logic         exp_ov;
        alu_op_e      op;
        int           errs_before;
        id          = rec[135:128];
        op          = alu_op_e'(rec[127:120]);
        flags       = rec[47:40];
        exp_res     = rec[39:8];
        exp_ov      = rec[0];
        errs_before = errors;
        timed_out   = 1'b0;

        @(negedge clk);
        op_i              = op;
        src_a_i           = rec[119:88];
        src_b_i           = rec[87:56];
        sa_i              = rec[52:48];
        flush_i           = 1'b0;
        flush_exception_i = flags[7];
        #2;
        check_stall(id, flags[6]);

        if (flags[3:0] != 4'h0) begin
            // abort the running unit part way through
            repeat (flags[3:0]) @(negedge clk);
            flush_i = 1'b1;
            #2;
            check_stall(id, 1'b0);
            @(negedge clk);
            drive_idle();
            #2;
            check_stall(id, 1'b0);
        end else begin
            wait_stall_low(timed_out);
            if (timed_out) begin
                $display("test %02h: stall_o still high after %0d cycles", id, TIMEOUT);
                errors++;
            end else begin
                assert (result_o === exp_res) else begin
                    $display("[FAIL] test %02h result_o got %h expected %h",
                             id, result_o, exp_res);
                    errors++;
                end
                assert (overflow_o === exp_ov) else begin
                    $display("[FAIL] test %02h overflow_o got %h expected %h",
                             id, overflow_o, exp_ov);
                    errors++;
                end
            end
        end
        tests++;
        $display("test %02h %s %s", id, op.name(), (errors == errs_before) ? "passed" : "failed");
    endtask

    // 0 to 3 idle cycles or none when the record asks for back-to-back issue
    task automatic idle_gap(input logic no_gap);
        int gap;
        gap = no_gap ? 0 : ($random(seed) & 3);
        repeat (gap) begin
            @(negedge clk);
            drive_idle();
        end
    endtask

    initial begin
        seed    = 32'hb874_cbcb;
        errors  = 0;
        tests   = 0;
        aborted = 1'b0;
        reset_i = 1'b1;
        drive_idle();
        for (int i = 0; i < MAX_RECS; i++) patterns[i] = '1;
        $readmemh("verif/alu_patterns.hex", patterns);

        repeat (8) @(posedge clk);
        @(negedge clk);
        reset_i = 1'b0;
        #2;
        check_stall(8'h00, 1'b0);

        // an id of ff marks the end of the loaded records
        for (int i = 0; i < MAX_RECS && patterns[i][135:128] != 8'hff && !aborted; i++) begin
            run_record(patterns[i], aborted);
            if (!aborted) idle_gap(patterns[i][45]);
        end

        $display("%0d tests run, %0d errors", tests, errors);
        if (errors == 0 && !aborted) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: exec_alu.f
+incdir+logic
logic/alu_pkg.sv
logic/muldiv_if.sv
logic/mul_unit.sv
logic/div_unit.sv
logic/hilo_reg.sv
logic/alu.sv
verif/tb_alu.sv

// File: verif/alu_patterns.hex
// id_op_srca_srcb_sa_flags_expected_ovf, flags [7] flush_exception [6] multi-cycle
// [5] next record back-to-back, [3:0] flush_i after that many stalled cycles
01_00_12345678_00000000_00_00_12345678_00
02_01_f0f01234_ff00ff00_00_00_f0001200_00
03_02_f0f01234_0f0000ff_00_00_fff012ff_00
04_03_f0f00000_0000ffff_00_00_0f0f0000_00
05_04_aaaa5555_ffff0000_00_00_55555555_00
06_05_7ffffff0_0000000f_00_00_7fffffff_00
07_05_7fffffff_00000001_00_00_80000000_01
08_06_ffffffff_00000002_00_00_00000001_00
09_07_80000000_00000001_00_00_7fffffff_01
0a_07_00000005_00000007_00_00_fffffffe_00
0b_08_00000000_00000001_00_00_ffffffff_00
0c_09_fffffffe_00000001_00_00_00000001_00
0d_0a_fffffffe_00000001_00_00_00000000_00
0e_0b_00000024_12345678_00_00_23456780_00
0f_0c_00000004_87654321_00_00_08765432_00
10_0d_00000008_87654321_00_00_ff876543_00
11_0e_ffffffff_00000003_1f_00_80000000_00
12_0f_ffffffff_abcd1234_10_00_0000abcd_00
13_10_ffffffff_f0000000_04_00_ff000000_00
14_11_00000000_deadbeef_00_00_beef0000_00
15_12_00000000_12345680_00_00_ffffff80_00
16_13_00000000_12348001_00_00_ffff8001_00
17_14_00000000_11223344_00_00_22114433_00
18_15_fffffffe_00000003_00_40_00000000_00
19_20_00000000_00000000_00_00_ffffffff_00
1a_21_00000000_00000000_00_00_fffffffa_00
1b_16_ffffffff_ffffffff_00_40_00000000_00
1c_20_00000000_00000000_00_00_fffffffe_00
1d_21_00000000_00000000_00_00_00000001_00
1e_17_fffffff9_00000002_00_40_00000000_00
1f_20_00000000_00000000_00_00_ffffffff_00
20_21_00000000_00000000_00_00_fffffffd_00
21_18_00000064_00000007_00_40_00000000_00
22_20_00000000_00000000_00_00_00000002_00
23_21_00000000_00000000_00_00_0000000e_00
24_18_12345678_00000000_00_40_00000000_00
25_20_00000000_00000000_00_00_12345678_00
26_21_00000000_00000000_00_00_ffffffff_00
27_19_fffffffd_00000005_00_60_fffffff1_00
28_19_fffffff0_00000010_00_40_ffffff00_00
29_20_00000000_00000000_00_00_12345678_00
2a_21_00000000_00000000_00_00_ffffffff_00
2b_15_00010000_00010000_00_60_00000000_00
2c_1a_00000003_ffffffff_00_40_00000000_00
2d_20_00000000_00000000_00_00_00000000_00
2e_21_00000000_00000000_00_00_fffffffd_00
2f_1e_00000001_00000000_00_00_00000000_00
30_21_00000000_00000000_00_00_fffffffd_00
31_1f_fffffff0_00000000_00_00_00000000_00
32_20_00000000_00000000_00_00_00000001_00
33_1a_00000002_00000010_00_40_00000000_00
34_20_00000000_00000000_00_00_00000002_00
35_21_00000000_00000000_00_00_00000010_00
36_1b_ffffffff_00000002_00_40_00000000_00
37_20_00000000_00000000_00_00_00000004_00
38_21_00000000_00000000_00_00_0000000e_00
39_1c_ffffffff_00000004_00_40_00000000_00
3a_1d_00000020_00000001_00_40_00000000_00
3b_20_00000000_00000000_00_00_00000003_00
3c_21_00000000_00000000_00_00_fffffff2_00
3d_1e_deadbeef_00000000_00_80_00000000_00
3e_15_00000002_00000003_00_c0_00000000_00
3f_17_00000064_00000007_00_45_00000000_00
40_20_00000000_00000000_00_00_00000003_00
41_21_00000000_00000000_00_00_fffffff2_00
42_17_ffffff9c_00000009_00_40_00000000_00
43_20_00000000_00000000_00_00_ffffffff_00
44_21_00000000_00000000_00_00_fffffff5_00
